// ==== source/lc4_params.svh ====
`ifndef LC4_PARAMS_SVH
`define LC4_PARAMS_SVH

// machine word, also the width of every address
`define LC4_WORD_W 16

// general purpose registers r0..r7
`define LC4_NREGS 8

// first fetch address after reset
`define LC4_RESET_PC 16'h8200

// opcode field inside an instruction
`define LC4_OPC_MSB 15
`define LC4_OPC_LSB 12

// BR with an empty nzp mask, never taken and writes nothing
`define LC4_NOP_INSN 16'h0000

`endif

// ==== source/lc4_pkg.sv ====
`include "lc4_params.svh"

package lc4_pkg;

    // data word and register index
    typedef logic [`LC4_WORD_W-1:0] word_t;
    typedef logic [$clog2(`LC4_NREGS)-1:0] rsel_t;

    // one-hot condition code, bit 2 negative, bit 1 zero, bit 0 positive
    typedef logic [2:0] nzp_t;

    // opcodes kept in this core, anything else decodes as a NOP
    typedef enum logic [3:0] {
        OPC_BR      = 4'b0000,
        OPC_ARITH   = 4'b0001,
        OPC_LOGIC   = 4'b0101,
        OPC_LDR     = 4'b0110,
        OPC_STR     = 4'b0111,
        OPC_CONST   = 4'b1001,
        OPC_JMP     = 4'b1100,
        OPC_HICONST = 4'b1101
    } opcode_t;

    // ALU function select
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_MUL,
        ALU_ADDI,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOT,
        ALU_ANDI,
        ALU_CONST,
        ALU_HICONST,
        ALU_MEM,
        ALU_BR,
        ALU_JMP
    } alu_op_t;

    // operand source, register file / memory stage / writeback stage
    typedef enum logic [1:0] {
        FWD_RF,
        FWD_M,
        FWD_W
    } fwd_t;

    // decoded controls, carried down the pipe with each instruction
    typedef struct packed {
        rsel_t   rs;
        rsel_t   rt;
        rsel_t   rd;
        logic    rs_re;
        logic    rt_re;
        logic    reg_we;
        logic    nzp_we;
        logic    is_load;
        logic    is_store;
        logic    is_branch;
        logic    is_jump;
        alu_op_t alu_op;
    } ctrl_t;

endpackage

// ==== source/lc4_decoder.sv ====
`include "lc4_params.svh"

module lc4_decoder import lc4_pkg::*; (
    input  word_t i_insn,
    output ctrl_t o_ctrl
);

    opcode_t    opc;
    logic [1:0] sub;

    assign opc = opcode_t'(i_insn[`LC4_OPC_MSB:`LC4_OPC_LSB]);
    // register-form sub-op, only meaningful when bit 5 is clear
    assign sub = i_insn[4:3];

    always_comb begin
        logic known;
        known = 1'b1;
        o_ctrl = '0;
        // common field positions, overridden below for STR and HICONST
        o_ctrl.rd = rsel_t'(i_insn[11:9]);
        o_ctrl.rs = rsel_t'(i_insn[8:6]);
        o_ctrl.rt = rsel_t'(i_insn[2:0]);
        case (opc)
            OPC_ARITH: begin
                o_ctrl.rs_re  = 1'b1;
                o_ctrl.reg_we = 1'b1;
                if (i_insn[5]) begin
                    o_ctrl.alu_op = ALU_ADDI;
                end else begin
                    o_ctrl.rt_re = 1'b1;
                    case (sub)
                        2'b00:   o_ctrl.alu_op = ALU_ADD;
                        2'b01:   o_ctrl.alu_op = ALU_MUL;
                        2'b10:   o_ctrl.alu_op = ALU_SUB;
                        // DIV is not implemented
                        default: known = 1'b0;
                    endcase
                end
            end
            OPC_LOGIC: begin
                o_ctrl.rs_re  = 1'b1;
                o_ctrl.reg_we = 1'b1;
                if (i_insn[5]) begin
                    o_ctrl.alu_op = ALU_ANDI;
                end else begin
                    // NOT is the only one that ignores rt
                    o_ctrl.rt_re = (sub != 2'b01);
                    case (sub)
                        2'b00:   o_ctrl.alu_op = ALU_AND;
                        2'b01:   o_ctrl.alu_op = ALU_NOT;
                        2'b10:   o_ctrl.alu_op = ALU_OR;
                        default: o_ctrl.alu_op = ALU_XOR;
                    endcase
                end
            end
            OPC_LDR: begin
                o_ctrl.rs_re   = 1'b1;
                o_ctrl.reg_we  = 1'b1;
                o_ctrl.is_load = 1'b1;
                o_ctrl.alu_op  = ALU_MEM;
            end
            OPC_STR: begin
                // store data register sits in the rd field
                o_ctrl.rt       = rsel_t'(i_insn[11:9]);
                o_ctrl.rs_re    = 1'b1;
                o_ctrl.rt_re    = 1'b1;
                o_ctrl.is_store = 1'b1;
                o_ctrl.alu_op   = ALU_MEM;
            end
            OPC_CONST: begin
                o_ctrl.reg_we = 1'b1;
                o_ctrl.alu_op = ALU_CONST;
            end
            OPC_HICONST: begin
                // keeps the low byte of rd, so rd is also a source
                o_ctrl.rs     = rsel_t'(i_insn[11:9]);
                o_ctrl.rs_re  = 1'b1;
                o_ctrl.reg_we = 1'b1;
                o_ctrl.alu_op = ALU_HICONST;
            end
            OPC_BR: begin
                o_ctrl.is_branch = 1'b1;
                o_ctrl.alu_op    = ALU_BR;
            end
            OPC_JMP: begin
                // bit 11 clear is JMPR, not supported
                o_ctrl.is_jump = i_insn[11];
                o_ctrl.alu_op  = ALU_JMP;
                known          = i_insn[11];
            end
            default: known = 1'b0;
        endcase
        // every register writer also sets nzp
        o_ctrl.nzp_we = o_ctrl.reg_we;
        if (!known) begin
            o_ctrl = '0;
        end
    end

endmodule

// ==== source/lc4_regfile.sv ====
`include "lc4_params.svh"

module lc4_regfile import lc4_pkg::*; (
    input  logic  gwe,
    input  logic  i_arst_n,
    input  rsel_t i_rs,
    input  rsel_t i_rt,
    output word_t o_rs_data,
    output word_t o_rt_data,
    input  rsel_t i_rd,
    input  word_t i_wdata,
    input  logic  i_we
);

    word_t regs [`LC4_NREGS];

    // single write port, driven from writeback
    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < `LC4_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we) begin
            regs[i_rd] <= i_wdata;
        end
    end

    // write-through, decode sees the value retiring this cycle
    assign o_rs_data = (i_we && (i_rd == i_rs)) ? i_wdata : regs[i_rs];
    assign o_rt_data = (i_we && (i_rd == i_rt)) ? i_wdata : regs[i_rt];

endmodule

// ==== source/lc4_alu.sv ====
`include "lc4_params.svh"

module lc4_alu import lc4_pkg::*; (
    input  alu_op_t i_op,
    input  word_t   i_insn,
    input  word_t   i_pc,
    input  word_t   i_a,
    input  word_t   i_b,
    output word_t   o_result
);

    word_t imm5;
    word_t imm6;
    word_t imm9;
    word_t imm11;
    word_t hi_byte;
    word_t pc_inc;

    // sign-extended immediates
    assign imm5  = {{(`LC4_WORD_W-5){i_insn[4]}}, i_insn[4:0]};
    assign imm6  = {{(`LC4_WORD_W-6){i_insn[5]}}, i_insn[5:0]};
    assign imm9  = {{(`LC4_WORD_W-9){i_insn[8]}}, i_insn[8:0]};
    assign imm11 = {{(`LC4_WORD_W-11){i_insn[10]}}, i_insn[10:0]};

    // HICONST upper byte
    assign hi_byte = {i_insn[7:0], {(`LC4_WORD_W-8){1'b0}}};

    // branch targets are relative to the next instruction
    assign pc_inc = i_pc + 1'b1;

    always_comb begin
        case (i_op)
            ALU_ADD:     o_result = i_a + i_b;
            ALU_SUB:     o_result = i_a - i_b;
            // low 16 bits of the product
            ALU_MUL:     o_result = i_a * i_b;
            ALU_ADDI:    o_result = i_a + imm5;
            ALU_AND:     o_result = i_a & i_b;
            ALU_OR:      o_result = i_a | i_b;
            ALU_XOR:     o_result = i_a ^ i_b;
            ALU_NOT:     o_result = ~i_a;
            ALU_ANDI:    o_result = i_a & imm5;
            ALU_CONST:   o_result = imm9;
            ALU_HICONST: o_result = (i_a & 16'h00ff) | hi_byte;
            // LDR and STR effective address
            ALU_MEM:     o_result = i_a + imm6;
            ALU_BR:      o_result = pc_inc + imm9;
            ALU_JMP:     o_result = pc_inc + imm11;
            default:     o_result = '0;
        endcase
    end

endmodule

// ==== source/lc4_hazard.sv ====
module lc4_hazard import lc4_pkg::*; (
    input  ctrl_t i_d_ctrl,
    input  ctrl_t i_x_ctrl,
    input  ctrl_t i_m_ctrl,
    input  ctrl_t i_w_ctrl,
    output logic  o_stall,
    output fwd_t  o_fwd_a,
    output fwd_t  o_fwd_b,
    output logic  o_fwd_st,
    output fwd_t  o_fwd_nzp
);

    logic ld_rs_hit;
    logic ld_rt_hit;

    // load in X feeding decode, data not ready until M
    assign ld_rs_hit = i_d_ctrl.rs_re && (i_d_ctrl.rs == i_x_ctrl.rd);
    // store data is patched later by the WM path, no need to wait
    assign ld_rt_hit = i_d_ctrl.rt_re && (i_d_ctrl.rt == i_x_ctrl.rd) && !i_d_ctrl.is_store;
    assign o_stall   = i_x_ctrl.is_load && i_x_ctrl.reg_we && (ld_rs_hit || ld_rt_hit);

    // MX before WX, the younger writer holds the newer value
    always_comb begin
        if (i_x_ctrl.rs_re && i_m_ctrl.reg_we && (i_x_ctrl.rs == i_m_ctrl.rd)) begin
            o_fwd_a = FWD_M;
        end else if (i_x_ctrl.rs_re && i_w_ctrl.reg_we && (i_x_ctrl.rs == i_w_ctrl.rd)) begin
            o_fwd_a = FWD_W;
        end else begin
            o_fwd_a = FWD_RF;
        end

        if (i_x_ctrl.rt_re && i_m_ctrl.reg_we && (i_x_ctrl.rt == i_m_ctrl.rd)) begin
            o_fwd_b = FWD_M;
        end else if (i_x_ctrl.rt_re && i_w_ctrl.reg_we && (i_x_ctrl.rt == i_w_ctrl.rd)) begin
            o_fwd_b = FWD_W;
        end else begin
            o_fwd_b = FWD_RF;
        end

        // branch condition from the nearest older nzp writer
        if (i_m_ctrl.nzp_we) begin
            o_fwd_nzp = FWD_M;
        end else if (i_w_ctrl.nzp_we) begin
            o_fwd_nzp = FWD_W;
        end else begin
            o_fwd_nzp = FWD_RF;
        end
    end

    // WM, store in M takes data retiring in W
    assign o_fwd_st = i_m_ctrl.is_store && i_w_ctrl.reg_we && (i_m_ctrl.rt == i_w_ctrl.rd);

endmodule

// ==== source/lc4_core.sv ====
`include "lc4_params.svh"

module lc4_core import lc4_pkg::*; (
    input  logic  gwe,
    input  logic  i_arst_n,
    output word_t o_imem_addr,
    input  word_t i_imem_data,
    output word_t o_dmem_addr,
    output logic  o_dmem_we,
    output word_t o_dmem_wdata,
    input  word_t i_dmem_rdata
);

    // fetch
    word_t f_pc;
    word_t f_pc_next;

    // decode
    word_t d_insn;
    word_t d_pc;
    ctrl_t d_ctrl;
    word_t d_rs_data;
    word_t d_rt_data;

    // execute
    word_t x_insn;
    word_t x_pc;
    ctrl_t x_ctrl;
    word_t x_a;
    word_t x_b;
    word_t x_op_a;
    word_t x_op_b;
    word_t x_alu;
    nzp_t  x_nzp;
    logic  x_taken;
    logic  x_flush;

    // memory
    ctrl_t m_ctrl;
    word_t m_alu;
    word_t m_b;
    word_t m_value;

    // writeback
    ctrl_t w_ctrl;
    word_t w_alu;
    word_t w_ld;
    word_t w_wdata;
    nzp_t  nzp_q;

    logic  stall;
    logic  fwd_st;
    fwd_t  fwd_a;
    fwd_t  fwd_b;
    fwd_t  fwd_nzp;

    function automatic nzp_t nzp_of(word_t v);
        if (v == '0) begin
            return 3'b010;
        end else if (v[`LC4_WORD_W-1]) begin
            return 3'b100;
        end
        return 3'b001;
    endfunction

    // redirect wins, a stall re-fetches the same word
    always_comb begin
        if (x_flush) begin
            f_pc_next = x_alu;
        end else if (stall) begin
            f_pc_next = f_pc;
        end else begin
            f_pc_next = f_pc + 1'b1;
        end
    end

    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            f_pc <= `LC4_RESET_PC;
        end else begin
            f_pc <= f_pc_next;
        end
    end

    assign o_imem_addr = f_pc;

    // F/D, killed on redirect, held on load-use
    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            d_insn <= `LC4_NOP_INSN;
        end else if (x_flush) begin
            d_insn <= `LC4_NOP_INSN;
        end else if (!stall) begin
            d_insn <= i_imem_data;
        end
    end

    always_ff @(posedge gwe) begin
        if (!stall) begin
            d_pc <= f_pc;
        end
    end

    lc4_decoder decoder_i (
        .i_insn (d_insn),
        .o_ctrl (d_ctrl)
    );

    lc4_regfile regfile_i (
        .gwe       (gwe),
        .i_arst_n  (i_arst_n),
        .i_rs      (d_ctrl.rs),
        .i_rt      (d_ctrl.rt),
        .o_rs_data (d_rs_data),
        .o_rt_data (d_rt_data),
        .i_rd      (w_ctrl.rd),
        .i_wdata   (w_wdata),
        .i_we      (w_ctrl.reg_we)
    );

    // D/X, a bubble goes in on stall or redirect
    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            x_ctrl <= '0;
            x_insn <= `LC4_NOP_INSN;
        end else if (x_flush || stall) begin
            x_ctrl <= '0;
            x_insn <= `LC4_NOP_INSN;
        end else begin
            x_ctrl <= d_ctrl;
            x_insn <= d_insn;
        end
    end

    always_ff @(posedge gwe) begin
        x_pc <= d_pc;
        x_a  <= d_rs_data;
        x_b  <= d_rt_data;
    end

    lc4_hazard hazard_i (
        .i_d_ctrl  (d_ctrl),
        .i_x_ctrl  (x_ctrl),
        .i_m_ctrl  (m_ctrl),
        .i_w_ctrl  (w_ctrl),
        .o_stall   (stall),
        .o_fwd_a   (fwd_a),
        .o_fwd_b   (fwd_b),
        .o_fwd_st  (fwd_st),
        .o_fwd_nzp (fwd_nzp)
    );

    // operand bypass into X
    always_comb begin
        case (fwd_a)
            FWD_M:   x_op_a = m_alu;
            FWD_W:   x_op_a = w_wdata;
            default: x_op_a = x_a;
        endcase
        case (fwd_b)
            FWD_M:   x_op_b = m_alu;
            FWD_W:   x_op_b = w_wdata;
            default: x_op_b = x_b;
        endcase
        // a load in M already has its data, so its nzp is usable here
        case (fwd_nzp)
            FWD_M:   x_nzp = nzp_of(m_value);
            FWD_W:   x_nzp = nzp_of(w_wdata);
            default: x_nzp = nzp_q;
        endcase
    end

    lc4_alu alu_i (
        .i_op     (x_ctrl.alu_op),
        .i_insn   (x_insn),
        .i_pc     (x_pc),
        .i_a      (x_op_a),
        .i_b      (x_op_b),
        .o_result (x_alu)
    );

    // nzp mask sits in bits 11:9 of BR
    assign x_taken = x_ctrl.is_branch && |(x_insn[11:9] & x_nzp);
    assign x_flush = x_taken || x_ctrl.is_jump;

    // X/M
    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            m_ctrl <= '0;
        end else begin
            m_ctrl <= x_ctrl;
        end
    end

    always_ff @(posedge gwe) begin
        m_alu <= x_alu;
        m_b   <= x_op_b;
    end

    assign m_value      = m_ctrl.is_load ? i_dmem_rdata : m_alu;
    assign o_dmem_addr  = m_alu;
    assign o_dmem_we    = m_ctrl.is_store;
    assign o_dmem_wdata = fwd_st ? w_wdata : m_b;

    // M/W
    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            w_ctrl <= '0;
        end else begin
            w_ctrl <= m_ctrl;
        end
    end

    always_ff @(posedge gwe) begin
        w_alu <= m_alu;
        w_ld  <= i_dmem_rdata;
    end

    assign w_wdata = w_ctrl.is_load ? w_ld : w_alu;

    // condition code follows the value written back
    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            nzp_q <= 3'b010;
        end else if (w_ctrl.nzp_we) begin
            nzp_q <= nzp_of(w_wdata);
        end
    end

endmodule

// ==== test/tb_lc4_mem.sv ====
`include "lc4_params.svh"

module tb_lc4_mem import lc4_pkg::*; (
    input  logic  gwe,
    input  word_t i_imem_addr,
    output word_t o_imem_data,
    input  word_t i_dmem_addr,
    input  logic  i_dmem_we,
    input  word_t i_dmem_wdata,
    output word_t o_dmem_rdata
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int ROM_WORDS = 64;
    localparam int RAM_WORDS = 256;

    word_t rom [ROM_WORDS];
    word_t ram [RAM_WORDS];
    word_t rom_index;

    // program starts at the reset PC, anything outside the ROM fetches a NOP
    assign rom_index = i_imem_addr - `LC4_RESET_PC;
    assign o_imem_data = (rom_index < word_t'(ROM_WORDS)) ? rom[rom_index[5:0]] : `LC4_NOP_INSN;

    // data RAM, only the low address byte selects a word
    assign o_dmem_rdata = ram[i_dmem_addr[7:0]];

    always @(posedge gwe) begin
        if (i_dmem_we) begin
            ram[i_dmem_addr[7:0]] <= i_dmem_wdata;
        end
    end

    initial begin
        integer seed;
        seed = 32'h1d156a02;
        // same seed and order as the mirror in tb_lc4_core
        for (int i = 0; i < RAM_WORDS; i++) begin
            ram[i] = word_t'($random(seed));
        end
        for (int i = 0; i < ROM_WORDS; i++) begin
            rom[i] = `LC4_NOP_INSN;
        end
        // r1 = 5, r2 = -3, add through WX and MX, store to 0
        rom[0]  = 16'h9205;
        rom[1]  = 16'h95fd;
        rom[2]  = 16'h1642;
        rom[3]  = 16'h77c0;
        // r4 = r2 - r1, r5 = r4 * r2, stores to 1 and 2
        rom[4]  = 16'h1891;
        rom[5]  = 16'h1b0a;
        rom[6]  = 16'h79c1;
        rom[7]  = 16'h7bc2;
        // r1 = 0xa5f3 and r2 = 0x3c5c from CONST plus HICONST
        rom[8]  = 16'h92f3;
        rom[9]  = 16'hd3a5;
        rom[10] = 16'h945c;
        rom[11] = 16'hd53c;
        // and, or, xor, not into r3..r6, stores to 3..6
        rom[12] = 16'h5642;
        rom[13] = 16'h5852;
        rom[14] = 16'h5a5a;
        rom[15] = 16'h5c48;
        rom[16] = 16'h77c3;
        rom[17] = 16'h79c4;
        rom[18] = 16'h7bc5;
        rom[19] = 16'h7dc6;
        // add imm -7 on r3, and imm 14 on r4, stores to 7 and 8
        rom[20] = 16'h16f9;
        rom[21] = 16'h592e;
        rom[22] = 16'h77c7;
        rom[23] = 16'h79c8;
        // r6 = 0x40, ldr r1 then addi uses it at once (stall), store to 9
        rom[24] = 16'h9c40;
        rom[25] = 16'h6385;
        rom[26] = 16'h1463;
        rom[27] = 16'h75c9;
        // ldr r3 then str r3 right after, data arrives by WM, store to 10
        rom[28] = 16'h6789;
        rom[29] = 16'h77ca;
        // r0 = marker, r1 = -1, BRn taken over two marker stores
        rom[30] = 16'h90ee;
        rom[31] = 16'h93ff;
        rom[32] = 16'h0802;
        rom[33] = 16'h71df;
        rom[34] = 16'h71df;
        // r2 = 0, BRnp falls through, store r1 to 11
        rom[35] = 16'h9400;
        rom[36] = 16'h0a01;
        rom[37] = 16'h73cb;
        // r3 = r2 + 4, BRp taken over two markers, store to 12
        rom[38] = 16'h16a4;
        rom[39] = 16'h0202;
        rom[40] = 16'h71df;
        rom[41] = 16'h71df;
        rom[42] = 16'h77cc;
        // jmp +3 over three markers, target stores 0x77 to 13
        rom[43] = 16'hc803;
        rom[44] = 16'h71df;
        rom[45] = 16'h71df;
        rom[46] = 16'h71df;
        rom[47] = 16'h9877;
        rom[48] = 16'h79cd;
    end

endmodule

// ==== test/tb_lc4_core.sv ====
`include "lc4_params.svh"

module tb_lc4_core import lc4_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int PROG_LEN   = 49;
    localparam int CLK_PERIOD = 8;
    localparam int RST_CYCLES = 16;
    // four cycles per instruction is far above stalls plus flushes
    localparam int TIMEOUT_CYCLES = PROG_LEN * 4 + RST_CYCLES;
    // value held in r0 and stored only from skipped slots
    localparam word_t MARKER = 16'h00ee;
    // operands built by CONST and HICONST in the program
    localparam word_t OPND_A = 16'ha5f3;
    localparam word_t OPND_B = 16'h3c5c;

    logic  gwe;
    logic  arst_n;
    word_t imem_addr;
    word_t imem_data;
    word_t dmem_addr;
    logic  dmem_we;
    word_t dmem_wdata;
    word_t dmem_rdata;

    word_t  ram_mirror [256];
    word_t  exp_addr [$];
    word_t  exp_data [$];
    int     n_expected;
    int     n_stores;
    integer seed;

    lc4_core dut_i (
        .gwe          (gwe),
        .i_arst_n     (arst_n),
        .o_imem_addr  (imem_addr),
        .i_imem_data  (imem_data),
        .o_dmem_addr  (dmem_addr),
        .o_dmem_we    (dmem_we),
        .o_dmem_wdata (dmem_wdata),
        .i_dmem_rdata (dmem_rdata)
    );

    tb_lc4_mem mem_i (
        .gwe          (gwe),
        .i_imem_addr  (imem_addr),
        .o_imem_data  (imem_data),
        .i_dmem_addr  (dmem_addr),
        .i_dmem_we    (dmem_we),
        .i_dmem_wdata (dmem_wdata),
        .o_dmem_rdata (dmem_rdata)
    );

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on a failed check");
    endtask

    task automatic expect_store(input word_t addr, input word_t data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    initial begin
        gwe = 1'b0;
        forever #(CLK_PERIOD / 2) gwe = ~gwe;
    end

    // watchdog
    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        report_failure($sformatf("program did not finish, %0d of %0d stores seen in %0d cycles",
                                 n_stores, n_expected, TIMEOUT_CYCLES));
    end

    // every data write is checked against the next expected store
    // outputs are sampled on the falling edge half a cycle before the write
    always @(negedge gwe) begin
        if (dmem_we) begin
            assert (dmem_wdata != MARKER) else
                report_failure("a store in the shadow of a taken branch or jump was executed");
            assert (dmem_addr == exp_addr[n_stores]) else
                report_failure($sformatf("[ERROR] o_dmem_addr expected 0x%h got 0x%h",
                                         exp_addr[n_stores], dmem_addr));
            assert (dmem_wdata == exp_data[n_stores]) else
                report_failure($sformatf("[ERROR] o_dmem_wdata expected 0x%h got 0x%h",
                                         exp_data[n_stores], dmem_wdata));
            n_stores = n_stores + 1;
        end
    end

    initial begin
        arst_n   = 1'b0;
        n_stores = 0;
        seed     = 32'h1d156a02;
        // same sequence the memory model loads into its RAM
        for (int i = 0; i < 256; i++) begin
            ram_mirror[i] = word_t'($random(seed));
        end

        // arithmetic results truncated to the word
        expect_store(16'h0000, 16'd5 + 16'hfffd);
        expect_store(16'h0001, 16'hfffd - 16'd5);
        expect_store(16'h0002, 16'hfff8 * 16'hfffd);
        // logic on the two built operands
        expect_store(16'h0003, OPND_A & OPND_B);
        expect_store(16'h0004, OPND_A | OPND_B);
        expect_store(16'h0005, OPND_A ^ OPND_B);
        expect_store(16'h0006, ~OPND_A);
        // immediates -7 and 14
        expect_store(16'h0007, (OPND_A & OPND_B) + 16'hfff9);
        expect_store(16'h0008, (OPND_A | OPND_B) & 16'h000e);
        // load-use and load then store
        expect_store(16'h0009, ram_mirror[8'h45] + 16'd3);
        expect_store(16'h000a, ram_mirror[8'h49]);
        // untaken BRnp stores r1 = -1, taken BRp lands on r3 = 0 + 4
        expect_store(16'h000b, 16'hffff);
        expect_store(16'h000c, 16'h0004);
        // first store at the JMP target
        expect_store(16'h000d, 16'h0077);
        n_expected = exp_addr.size();

        // nothing may be written and fetch stays at the reset PC
        repeat (RST_CYCLES) begin
            @(negedge gwe);
            assert (!dmem_we) else
                report_failure("o_dmem_we was high while reset was asserted");
            assert (imem_addr == `LC4_RESET_PC) else
                report_failure($sformatf("[ERROR] o_imem_addr expected 0x%h got 0x%h",
                                         `LC4_RESET_PC, imem_addr));
        end
        arst_n = 1'b1;
        #1;
        assert (!dmem_we) else
            report_failure("o_dmem_we was high at reset release");
        assert (imem_addr == `LC4_RESET_PC) else
            report_failure($sformatf("[ERROR] o_imem_addr expected 0x%h got 0x%h",
                                     `LC4_RESET_PC, imem_addr));

        wait (n_stores == n_expected);
        $display("TEST OK");
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+source
source/lc4_pkg.sv
source/lc4_decoder.sv
source/lc4_regfile.sv
source/lc4_alu.sv
source/lc4_hazard.sv
source/lc4_core.sv
test/tb_lc4_mem.sv
test/tb_lc4_core.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the LC4 pipeline testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -j 0 \
    --top-module tb_lc4_core \
    -f tb.f \
    -o tb_lc4_core_sim

# pass only if the simulation printed its pass line
if ./obj_dir/tb_lc4_core_sim | tee /dev/stderr | grep -x "TEST OK" > /dev/null; then
    exit 0
fi
exit 1
